//--- mcu_map_pkg.sv
`default_nettype none

package mcu_map_pkg;

  // Memory address space
  localparam int ADDR_W = 24;
  localparam int N_PTR = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [2:0] mapper_t;
  typedef logic [7:0] byte_t;
  typedef logic [1:0] ptr_idx_t;

  // Bus frequency counter word
  typedef logic [31:0] freq_t;

  localparam mapper_t MAPPER_RESET = 3'd1;

endpackage

`default_nettype wire

//--- mcu_cmd_pkg.sv
`default_nettype none

package mcu_cmd_pkg;

  typedef logic [31:0] byte_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Opcode nibbles, cmd_data[7:4]
  //////////////////////////////////////////////////////////////////////
  localparam logic [3:0] OP_SET_PTR = 4'h0;
  localparam logic [3:0] OP_ROM_MASK = 4'h1;
  localparam logic [3:0] OP_SRAM_MASK = 4'h2;
  localparam logic [3:0] OP_MAPPER = 4'h3;
  localparam logic [3:0] OP_READ = 4'h8;
  localparam logic [3:0] OP_WRITE = 4'h9;

  //////////////////////////////////////////////////////////////////////
  // Full opcodes
  //////////////////////////////////////////////////////////////////////
  localparam logic [7:0] OP_SIGNATURE = 8'hf0;
  localparam logic [7:0] OP_FREQ_FIRST = 8'hf6;
  localparam logic [7:0] OP_FREQ_LAST = 8'hf9;
  localparam logic [7:0] OP_ECHO = 8'hff;

  localparam logic [7:0] SIGNATURE_BYTE = 8'ha5;

  // Byte counts of a three-byte load
  localparam byte_cnt_t BYTE_HI = 32'd2;
  localparam byte_cnt_t BYTE_MID = 32'd3;
  localparam byte_cnt_t BYTE_LO = 32'd4;

  // Counter snapshot point
  localparam byte_cnt_t FREQ_SNAP = 32'd1;

endpackage

`default_nettype wire

//--- addr_pointer.sv
`timescale 1ns/1ps
`default_nettype none

module addr_pointer #(
  parameter int ADDR_W = 24
) (
  input wire clk,
  input wire reset,
  input wire load,
  input wire [1:0] load_pos,
  input wire mcu_map_pkg::byte_t load_byte,
  input wire advance,
  output logic [ADDR_W-1:0] addr
);

  // Position 2 is the high byte, 0 the low byte
  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
    end else if (load) begin
      if (load_pos == 2'd2) begin
        addr <= '0;
        addr[16 +: 8] <= load_byte;
      end else begin
        addr[load_pos*8 +: 8] <= load_byte;
      end
    end else if (advance) begin
      addr <= addr + 1'b1;
    end
  end

  // Loads only happen under set-pointer, advances only under read/write
  a_load_advance_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && advance));

endmodule

`default_nettype wire

//--- cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
  input wire clk,
  input wire reset,
  input wire cmd_ready,
  input wire param_ready,
  input wire mcu_map_pkg::byte_t cmd_data,
  input wire mcu_map_pkg::byte_t param_data,
  input wire mcu_cmd_pkg::byte_cnt_t spi_byte_cnt,
  input wire mcu_nextaddr,
  output mcu_map_pkg::mapper_t mcu_mapper,
  output mcu_map_pkg::addr_t rom_mask_out,
  output mcu_map_pkg::addr_t saveram_mask_out,
  output logic [mcu_map_pkg::N_PTR-1:0] ptr_load,
  output logic [1:0] ptr_load_pos,
  output mcu_map_pkg::byte_t ptr_load_byte,
  output logic [mcu_map_pkg::N_PTR-1:0] ptr_advance
);

  import mcu_map_pkg::*;
  import mcu_cmd_pkg::*;

  logic [3:0] op_nib;
  logic lane_hit;
  logic [1:0] lane_pos;
  ptr_idx_t load_sel;
  ptr_idx_t target;
  logic adv_en;

  assign op_nib = cmd_data[7:4];

  // Byte count to byte lane, high byte first
  always_comb begin
    lane_hit = 1'b1;
    lane_pos = 2'd0;
    case (spi_byte_cnt)
      BYTE_HI: lane_pos = 2'd2;
      BYTE_MID: lane_pos = 2'd1;
      BYTE_LO: lane_pos = 2'd0;
      default: lane_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mcu_mapper <= MAPPER_RESET;
      rom_mask_out <= '0;
      saveram_mask_out <= '0;
      target <= '0;
    end else if (cmd_ready) begin
      case (op_nib)
        OP_MAPPER: mcu_mapper <= cmd_data[2:0];
        OP_READ: target <= '0;
        OP_WRITE: target <= cmd_data[1:0];
        default: ;
      endcase
    end else if (param_ready && lane_hit) begin
      case (op_nib)
        OP_ROM_MASK: rom_mask_out[lane_pos*8 +: 8] <= param_data;
        OP_SRAM_MASK: saveram_mask_out[lane_pos*8 +: 8] <= param_data;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointer load and advance strobes
  //////////////////////////////////////////////////////////////////////

  // Index 3 falls back to the memory pointer
  assign load_sel = (cmd_data[1:0] == 2'd3) ? ptr_idx_t'(0) : cmd_data[1:0];

  assign adv_en = mcu_nextaddr && (op_nib == OP_READ || op_nib == OP_WRITE)
                  && cmd_data[3]
                  && (spi_byte_cnt >= byte_cnt_t'(cmd_data[4]) + 32'd1);

  always_comb begin
    for (int i = 0; i < N_PTR; i++) begin
      ptr_load[i] = param_ready && (op_nib == OP_SET_PTR) && lane_hit
                    && (load_sel == ptr_idx_t'(i));
      ptr_advance[i] = adv_en && (target == ptr_idx_t'(i));
    end
  end

  assign ptr_load_pos = lane_pos;
  assign ptr_load_byte = param_data;

  a_load_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(ptr_load));

endmodule

`default_nettype wire

//--- mcu_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_bus_port (
  input wire clk,
  input wire reset,
  input wire cmd_ready,
  input wire param_ready,
  input wire mcu_map_pkg::byte_t cmd_data,
  input wire mcu_map_pkg::byte_t param_data,
  input wire mcu_rq_rdy,
  output logic mcu_rrq,
  output logic mcu_wrq,
  output mcu_map_pkg::byte_t mcu_data_out,
  output logic mcu_nextaddr
);

  import mcu_cmd_pkg::*;

  typedef enum logic [1:0] {
    ST_RQ = 2'b01,
    ST_IDLE = 2'b10
  } rq_state_t;

  localparam int RD = 0;
  localparam int WR = 1;

  logic [1:0] rq_start;
  logic [1:0] rq_pulse;
  rq_state_t rq_state [2];
  logic [1:0] rdy_hist;

  assign rq_start[RD] = (cmd_ready || param_ready) && (cmd_data[7:4] == OP_READ);
  assign rq_start[WR] = param_ready && (cmd_data[7:4] == OP_WRITE);

  // One-cycle request pulse per channel
  always_ff @(posedge clk) begin
    if (reset) begin
      rq_state <= '{default: ST_IDLE};
      rq_pulse <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (rq_state[i])
          ST_IDLE: begin
            if (rq_start[i]) begin
              rq_pulse[i] <= 1'b1;
              rq_state[i] <= ST_RQ;
            end
          end
          default: begin
            rq_pulse[i] <= 1'b0;
            rq_state[i] <= ST_IDLE;
          end
        endcase
      end
    end
  end

  assign mcu_rrq = rq_pulse[RD];
  assign mcu_wrq = rq_pulse[WR];

  always_ff @(posedge clk) begin
    if (reset) begin
      mcu_data_out <= '0;
    end else if (rq_start[WR] && rq_state[WR] == ST_IDLE) begin
      mcu_data_out <= param_data;
    end
  end

  // Rising edge of the done level, delayed one more cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rdy_hist <= '0;
      mcu_nextaddr <= 1'b0;
    end else begin
      rdy_hist <= {rdy_hist[0], mcu_rq_rdy};
      mcu_nextaddr <= (rdy_hist == 2'b01);
    end
  end

  a_rq_excl: assert property (@(posedge clk) disable iff (reset)
    !(mcu_rrq && mcu_wrq));

endmodule

`default_nettype wire

//--- spi_readback.sv
`timescale 1ns/1ps
`default_nettype none

module spi_readback (
  input wire clk,
  input wire reset,
  input wire cmd_ready,
  input wire param_ready,
  input wire mcu_map_pkg::byte_t cmd_data,
  input wire mcu_map_pkg::byte_t param_data,
  input wire mcu_cmd_pkg::byte_cnt_t spi_byte_cnt,
  input wire mcu_nextaddr,
  input wire mcu_map_pkg::byte_t mcu_data_in,
  input wire mcu_map_pkg::freq_t cicclk_freq,
  input wire mcu_map_pkg::freq_t romsel_freq,
  input wire mcu_map_pkg::freq_t cpuclk_freq,
  input wire mcu_map_pkg::freq_t read_freq,
  output mcu_map_pkg::byte_t spi_data_out
);

  import mcu_map_pkg::*;
  import mcu_cmd_pkg::*;

  localparam int FREQ_BYTES = $bits(freq_t) / 8;

  logic strobe;
  logic rd_capture;
  logic freq_op;
  logic [1:0] freq_idx;
  logic snap_now;
  logic shift_now;
  freq_t freq_sel;
  freq_t freq_shift;

  assign strobe = cmd_ready || param_ready;
  assign rd_capture = (cmd_data[7:4] == OP_READ) && mcu_nextaddr;
  assign freq_op = (cmd_data >= OP_FREQ_FIRST) && (cmd_data <= OP_FREQ_LAST);
  assign freq_idx = 2'(cmd_data - OP_FREQ_FIRST);

  assign snap_now = strobe && freq_op && (spi_byte_cnt == FREQ_SNAP);
  assign shift_now = strobe && freq_op && (spi_byte_cnt > FREQ_SNAP)
                     && (spi_byte_cnt <= FREQ_SNAP + byte_cnt_t'(FREQ_BYTES));

  always_comb begin
    case (freq_idx)
      2'd0: freq_sel = cicclk_freq;
      2'd1: freq_sel = romsel_freq;
      2'd2: freq_sel = cpuclk_freq;
      default: freq_sel = read_freq;
    endcase
  end

  // Counter snapshot, MSB first
  always_ff @(posedge clk) begin
    if (snap_now) begin
      freq_shift <= freq_sel;
    end else if (shift_now) begin
      freq_shift <= {freq_shift[$bits(freq_t)-9:0], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      spi_data_out <= '0;
    end else if (rd_capture) begin
      spi_data_out <= mcu_data_in;
    end else if (strobe) begin
      if (cmd_data == OP_SIGNATURE) begin
        spi_data_out <= SIGNATURE_BYTE;
      end else if (cmd_data == OP_ECHO) begin
        spi_data_out <= param_data;
      end else if (shift_now) begin
        spi_data_out <= freq_shift[$bits(freq_t)-1 -: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- mcu_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd_top #(
  parameter int ADDR_W = mcu_map_pkg::ADDR_W
) (
  input wire clk,
  input wire reset,
  input wire cmd_ready,
  input wire param_ready,
  input wire mcu_map_pkg::byte_t cmd_data,
  input wire mcu_map_pkg::byte_t param_data,
  input wire mcu_cmd_pkg::byte_cnt_t spi_byte_cnt,
  input wire mcu_rq_rdy,
  input wire mcu_map_pkg::byte_t mcu_data_in,
  input wire mcu_map_pkg::freq_t cicclk_freq,
  input wire mcu_map_pkg::freq_t romsel_freq,
  input wire mcu_map_pkg::freq_t cpuclk_freq,
  input wire mcu_map_pkg::freq_t read_freq,
  output mcu_map_pkg::mapper_t mcu_mapper,
  output logic mcu_rrq,
  output logic mcu_wrq,
  output mcu_map_pkg::byte_t mcu_data_out,
  output mcu_map_pkg::byte_t spi_data_out,
  output mcu_map_pkg::addr_t rom_mask_out,
  output mcu_map_pkg::addr_t saveram_mask_out,
  output mcu_map_pkg::addr_t addr_out,
  output mcu_map_pkg::addr_t dac_addr_out,
  output mcu_map_pkg::addr_t msu_addr_out
);

  import mcu_map_pkg::*;

  logic mcu_nextaddr;
  logic [N_PTR-1:0] ptr_load;
  logic [1:0] ptr_load_pos;
  byte_t ptr_load_byte;
  logic [N_PTR-1:0] ptr_advance;
  logic [ADDR_W-1:0] ptr_addr [N_PTR];

  cmd_decode cmd_decode_i (
    .clk(clk),
    .reset(reset),
    .cmd_ready(cmd_ready),
    .param_ready(param_ready),
    .cmd_data(cmd_data),
    .param_data(param_data),
    .spi_byte_cnt(spi_byte_cnt),
    .mcu_nextaddr(mcu_nextaddr),
    .mcu_mapper(mcu_mapper),
    .rom_mask_out(rom_mask_out),
    .saveram_mask_out(saveram_mask_out),
    .ptr_load(ptr_load),
    .ptr_load_pos(ptr_load_pos),
    .ptr_load_byte(ptr_load_byte),
    .ptr_advance(ptr_advance)
  );

  // Pointer bank: memory, audio buffer, streaming buffer
  for (genvar i = 0; i < N_PTR; i++) begin : g_ptr
    addr_pointer #(
      .ADDR_W(ADDR_W)
    ) ptr_i (
      .clk(clk),
      .reset(reset),
      .load(ptr_load[i]),
      .load_pos(ptr_load_pos),
      .load_byte(ptr_load_byte),
      .advance(ptr_advance[i]),
      .addr(ptr_addr[i])
    );
  end

  assign addr_out = ptr_addr[0];
  assign dac_addr_out = ptr_addr[1];
  assign msu_addr_out = ptr_addr[2];

  mcu_bus_port bus_port_i (
    .clk(clk),
    .reset(reset),
    .cmd_ready(cmd_ready),
    .param_ready(param_ready),
    .cmd_data(cmd_data),
    .param_data(param_data),
    .mcu_rq_rdy(mcu_rq_rdy),
    .mcu_rrq(mcu_rrq),
    .mcu_wrq(mcu_wrq),
    .mcu_data_out(mcu_data_out),
    .mcu_nextaddr(mcu_nextaddr)
  );

  spi_readback readback_i (
    .clk(clk),
    .reset(reset),
    .cmd_ready(cmd_ready),
    .param_ready(param_ready),
    .cmd_data(cmd_data),
    .param_data(param_data),
    .spi_byte_cnt(spi_byte_cnt),
    .mcu_nextaddr(mcu_nextaddr),
    .mcu_data_in(mcu_data_in),
    .cicclk_freq(cicclk_freq),
    .romsel_freq(romsel_freq),
    .cpuclk_freq(cpuclk_freq),
    .read_freq(read_freq),
    .spi_data_out(spi_data_out)
  );

endmodule

`default_nettype wire

//--- tb_mcu_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_cmd;

  import mcu_map_pkg::*;

  localparam int unsigned SEED = 51703;
  // About 600 cycles of sequences, so the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  localparam freq_t CIC_FREQ = 32'h0036_6e01;
  localparam freq_t ROMSEL_FREQ = 32'h0146_b25c;
  localparam freq_t CPUCLK_FREQ = 32'h0147_9d0a;
  localparam freq_t READ_FREQ = 32'h00a3_49f7;

  logic clk;
  logic reset;
  logic cmd_ready;
  logic param_ready;
  byte_t cmd_data;
  byte_t param_data;
  logic [31:0] spi_byte_cnt;
  logic mcu_rq_rdy;
  byte_t mcu_data_in;
  freq_t cicclk_freq;
  freq_t romsel_freq;
  freq_t cpuclk_freq;
  freq_t read_freq;

  mapper_t mcu_mapper;
  logic mcu_rrq;
  logic mcu_wrq;
  byte_t mcu_data_out;
  byte_t spi_data_out;
  addr_t rom_mask_out;
  addr_t saveram_mask_out;
  addr_t addr_out;
  addr_t dac_addr_out;
  addr_t msu_addr_out;

  // Reference model state
  mapper_t exp_mapper;
  addr_t exp_rom;
  addr_t exp_sram;
  addr_t exp_ptr [3];
  logic [1:0] exp_target;
  logic exp_rrq;
  logic exp_wrq;
  byte_t exp_dout;
  byte_t exp_spi;
  freq_t exp_snap;

  int cycles;
  int unsigned accesses_done;
  int arb_lat;
  logic arb_read;

  mcu_cmd_top dut_i (
    .clk(clk),
    .reset(reset),
    .cmd_ready(cmd_ready),
    .param_ready(param_ready),
    .cmd_data(cmd_data),
    .param_data(param_data),
    .spi_byte_cnt(spi_byte_cnt),
    .mcu_rq_rdy(mcu_rq_rdy),
    .mcu_data_in(mcu_data_in),
    .cicclk_freq(cicclk_freq),
    .romsel_freq(romsel_freq),
    .cpuclk_freq(cpuclk_freq),
    .read_freq(read_freq),
    .mcu_mapper(mcu_mapper),
    .mcu_rrq(mcu_rrq),
    .mcu_wrq(mcu_wrq),
    .mcu_data_out(mcu_data_out),
    .spi_data_out(spi_data_out),
    .rom_mask_out(rom_mask_out),
    .saveram_mask_out(saveram_mask_out),
    .addr_out(addr_out),
    .dac_addr_out(dac_addr_out),
    .msu_addr_out(msu_addr_out)
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    $display("Errors found");
    $fatal(1, "Output check failed");
  endtask

  function automatic freq_t freq_for(input byte_t cmd);
    case (cmd)
      8'hf6: return cicclk_freq;
      8'hf7: return romsel_freq;
      8'hf8: return cpuclk_freq;
      default: return read_freq;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Expected state after one strobe
  //////////////////////////////////////////////////////////////////////
  task automatic apply_rules(input logic is_cmd, input byte_t cmd, input byte_t prm,
                             input int unsigned cnt);
    logic [3:0] nib;
    int lane;
    int idx;
    nib = cmd[7:4];
    lane = 4 - int'(cnt);
    idx = (cmd[1:0] == 2'd3) ? 0 : int'(cmd[1:0]);
    if (is_cmd) begin
      if (nib == 4'h3) exp_mapper = cmd[2:0];
      if (nib == 4'h8) exp_target = 2'd0;
      if (nib == 4'h9) exp_target = cmd[1:0];
    end else if (cnt >= 2 && cnt <= 4) begin
      if (nib == 4'h1) exp_rom[lane*8 +: 8] = prm;
      if (nib == 4'h2) exp_sram[lane*8 +: 8] = prm;
      if (nib == 4'h0 && cnt == 2) exp_ptr[idx] = {prm, 16'h0000};
      if (nib == 4'h0 && cnt != 2) exp_ptr[idx][lane*8 +: 8] = prm;
    end
    if (nib == 4'h8) exp_rrq = 1'b1;
    if (nib == 4'h9 && !is_cmd) begin
      exp_wrq = 1'b1;
      exp_dout = prm;
    end
    if (cmd == 8'hf0) begin
      exp_spi = 8'ha5;
    end else if (cmd == 8'hff) begin
      exp_spi = prm;
    end else if (cmd >= 8'hf6 && cmd <= 8'hf9) begin
      if (cnt == 1) exp_snap = freq_for(cmd);
      if (cnt >= 2 && cnt <= 5) exp_spi = exp_snap[8*(5-cnt) +: 8];
    end
  endtask

  // Pointer advance and read capture at access done
  task automatic finish_access(input logic was_read);
    logic [3:0] nib;
    nib = cmd_data[7:4];
    if ((nib == 4'h8 || nib == 4'h9) && cmd_data[3]
        && spi_byte_cnt >= 32'd1 + 32'(cmd_data[4]) && exp_target != 2'd3) begin
      exp_ptr[exp_target] = exp_ptr[exp_target] + 1'b1;
    end
    if (was_read) exp_spi = mcu_data_in;
  endtask

  // One strobe, held for a single cycle
  task automatic drive_strobe(input logic is_cmd, input byte_t cmd, input byte_t prm,
                              input int unsigned cnt);
    cmd_data = cmd;
    param_data = prm;
    spi_byte_cnt = cnt;
    cmd_ready = is_cmd;
    param_ready = !is_cmd;
    @(negedge clk);
    cmd_ready = 1'b0;
    param_ready = 1'b0;
    apply_rules(is_cmd, cmd, prm, cnt);
    @(negedge clk);
    exp_rrq = 1'b0;
    exp_wrq = 1'b0;
  endtask

  // Strobe that starts a memory access, then wait until it is done
  task automatic strobe_access(input logic is_cmd, input byte_t cmd, input int unsigned cnt,
                               input int unsigned cnt_during);
    int unsigned start;
    start = accesses_done;
    drive_strobe(is_cmd, cmd, byte_t'($urandom), cnt);
    spi_byte_cnt = cnt_during;
    while (accesses_done == start) @(negedge clk);
    @(negedge clk);
  endtask

  // Memory arbiter: done level 1 to 4 cycles after a request, held two cycles
  always begin
    @(negedge clk);
    if (!reset && (mcu_rrq || mcu_wrq)) begin
      arb_read = mcu_rrq;
      arb_lat = $urandom_range(1, 4);
      repeat (arb_lat - 1) @(negedge clk);
      mcu_data_in = byte_t'($urandom);
      mcu_rq_rdy = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      mcu_rq_rdy = 1'b0;
      @(posedge clk);
      @(negedge clk);
      finish_access(arb_read);
      accesses_done++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////////////////////////
  a_mapper: assert property (@(posedge clk) disable iff (reset) mcu_mapper == exp_mapper)
    else report_mismatch("mcu_mapper", $sampled(exp_mapper), $sampled(mcu_mapper));
  a_rom: assert property (@(posedge clk) disable iff (reset) rom_mask_out == exp_rom)
    else report_mismatch("rom_mask_out", $sampled(exp_rom), $sampled(rom_mask_out));
  a_sram: assert property (@(posedge clk) disable iff (reset) saveram_mask_out == exp_sram)
    else report_mismatch("saveram_mask_out", $sampled(exp_sram), $sampled(saveram_mask_out));
  a_addr: assert property (@(posedge clk) disable iff (reset) addr_out == exp_ptr[0])
    else report_mismatch("addr_out", $sampled(exp_ptr[0]), $sampled(addr_out));
  a_dac: assert property (@(posedge clk) disable iff (reset) dac_addr_out == exp_ptr[1])
    else report_mismatch("dac_addr_out", $sampled(exp_ptr[1]), $sampled(dac_addr_out));
  a_msu: assert property (@(posedge clk) disable iff (reset) msu_addr_out == exp_ptr[2])
    else report_mismatch("msu_addr_out", $sampled(exp_ptr[2]), $sampled(msu_addr_out));
  a_dout: assert property (@(posedge clk) disable iff (reset) mcu_data_out == exp_dout)
    else report_mismatch("mcu_data_out", $sampled(exp_dout), $sampled(mcu_data_out));
  a_spi: assert property (@(posedge clk) disable iff (reset) spi_data_out == exp_spi)
    else report_mismatch("spi_data_out", $sampled(exp_spi), $sampled(spi_data_out));
  a_rrq: assert property (@(posedge clk) disable iff (reset) mcu_rrq == exp_rrq)
    else report_mismatch("mcu_rrq", $sampled(exp_rrq), $sampled(mcu_rrq));
  a_wrq: assert property (@(posedge clk) disable iff (reset) mcu_wrq == exp_wrq)
    else report_mismatch("mcu_wrq", $sampled(exp_wrq), $sampled(mcu_wrq));

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cmd_ready = 1'b0;
    param_ready = 1'b0;
    cmd_data = '0;
    param_data = '0;
    spi_byte_cnt = '0;
    mcu_rq_rdy = 1'b0;
    mcu_data_in = '0;
    cicclk_freq = CIC_FREQ;
    romsel_freq = ROMSEL_FREQ;
    cpuclk_freq = CPUCLK_FREQ;
    read_freq = READ_FREQ;
    exp_mapper = 3'd1;
    exp_rom = '0;
    exp_sram = '0;
    exp_ptr = '{default: '0};
    exp_target = '0;
    exp_rrq = 1'b0;
    exp_wrq = 1'b0;
    exp_dout = '0;
    exp_spi = '0;
    exp_snap = '0;
    cycles = 0;
    accesses_done = 0;
    void'($urandom(SEED));
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);

    // Mapper and masks
    for (int m = 0; m < 8; m++) begin
      drive_strobe(1'b1, 8'h30 | byte_t'(m), 8'h00, 0);
    end
    for (int r = 0; r < 3; r++) begin
      for (int op = 1; op <= 2; op++) begin
        drive_strobe(1'b1, byte_t'(op << 4), 8'h00, 0);
        for (int c = 2; c <= 4; c++) begin
          drive_strobe(1'b0, byte_t'(op << 4), byte_t'($urandom), c);
        end
      end
    end

    // Pointer loads, index 3 lands on pointer 0
    for (int r = 0; r < 2; r++) begin
      for (int p = 0; p < 4; p++) begin
        drive_strobe(1'b1, byte_t'(p), 8'h00, 0);
        for (int c = 2; c <= 4; c++) begin
          drive_strobe(1'b0, byte_t'(p), byte_t'($urandom), c);
        end
      end
    end
    for (int p = 1; p < 3; p++) begin
      drive_strobe(1'b0, byte_t'(p), byte_t'($urandom), 2);
    end
    drive_strobe(1'b0, 8'h00, 8'hff, 2);
    drive_strobe(1'b0, 8'h00, 8'hff, 3);
    drive_strobe(1'b0, 8'h00, 8'hfe, 4);

    // Reads, one with bit 3 clear
    for (int k = 0; k < 3; k++) begin
      strobe_access(1'b1, (k == 1) ? 8'h80 : 8'h88 | byte_t'(k), 0, 1);
      for (int c = 1; c <= 3; c++) begin
        strobe_access(1'b0, (k == 1) ? 8'h80 : 8'h88 | byte_t'(k), c, c);
      end
    end
    strobe_access(1'b1, 8'h88, 0, 0);

    // Writes to each target, and one with bit 3 clear
    for (int p = 0; p < 4; p++) begin
      drive_strobe(1'b1, 8'h98 | byte_t'(p), 8'h00, 0);
      for (int c = 1; c <= 3; c++) begin
        strobe_access(1'b0, 8'h98 | byte_t'(p), c, c);
      end
    end
    drive_strobe(1'b1, 8'h91, 8'h00, 0);
    strobe_access(1'b0, 8'h91, 1, 2);
    strobe_access(1'b0, 8'h91, 2, 2);

    // A read moves the target back to the memory pointer
    strobe_access(1'b1, 8'h88, 0, 1);

    // Readback: signature, echo, counters
    drive_strobe(1'b1, 8'hf0, 8'h00, 0);
    drive_strobe(1'b0, 8'hf0, byte_t'($urandom), 1);
    drive_strobe(1'b1, 8'hff, byte_t'($urandom), 0);
    for (int c = 1; c <= 3; c++) begin
      drive_strobe(1'b0, 8'hff, byte_t'($urandom), c);
    end
    for (int f = 6; f <= 9; f++) begin
      drive_strobe(1'b1, 8'hf0 | byte_t'(f), 8'h00, 0);
      for (int c = 1; c <= 5; c++) begin
        drive_strobe(1'b0, 8'hf0 | byte_t'(f), byte_t'($urandom), c);
      end
    end

    repeat (4) @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- mcu_cmd_top.f
mcu_map_pkg.sv
mcu_cmd_pkg.sv
addr_pointer.sv
cmd_decode.sv
mcu_bus_port.sv
spi_readback.sv
mcu_cmd_top.sv
tb_mcu_cmd.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_mcu_cmd -f mcu_cmd_top.f

# A failing run exits nonzero; the log decides the result
./obj_dir/Vtb_mcu_cmd > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
